/* flist.f */
verilog/la32_pkg.sv
verilog/dec_if.sv
verilog/la32_decoder.sv
verilog/la32_regfile.sv
verilog/la32_alu.sv
verilog/la32_core.sv
verif/tb_clock.sv
verif/la32_core_props.sv
verif/tb_top.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the la32_core testbench with Verilator.
cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert --top-module tb_top -f flist.f -o tb_sim \
    && ./obj_dir/tb_sim | tee sim.log \
    && grep -q '^\*\* PASS \*\*$' sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* verif/tb_top.sv */
module tb_top;

    timeunit 1ns;
    timeprecision 100ps;

    typedef struct {
        la32_pkg::word_t    pc;
        la32_pkg::word_t    inst;
        la32_pkg::inst_e    op;
        logic               we;
        la32_pkg::reg_idx_t wnum;
        la32_pkg::word_t    wdata;
    } row_t;

    // LA32R opcode bits with every register and immediate field zero.
    localparam la32_pkg::word_t OP_ADD_W   = 32'h00100000;
    localparam la32_pkg::word_t OP_SUB_W   = 32'h00110000;
    localparam la32_pkg::word_t OP_SLT     = 32'h00120000;
    localparam la32_pkg::word_t OP_SLTU    = 32'h00128000;
    localparam la32_pkg::word_t OP_NOR     = 32'h00140000;
    localparam la32_pkg::word_t OP_AND     = 32'h00148000;
    localparam la32_pkg::word_t OP_OR      = 32'h00150000;
    localparam la32_pkg::word_t OP_XOR     = 32'h00158000;
    localparam la32_pkg::word_t OP_SLLI_W  = 32'h00408000;
    localparam la32_pkg::word_t OP_SRLI_W  = 32'h00448000;
    localparam la32_pkg::word_t OP_SRAI_W  = 32'h00488000;
    localparam la32_pkg::word_t OP_ADDI_W  = 32'h02800000;
    localparam la32_pkg::word_t OP_LU12I_W = 32'h14000000;
    localparam la32_pkg::word_t OP_LD_W    = 32'h28800000;
    localparam la32_pkg::word_t OP_ST_W    = 32'h29800000;
    localparam la32_pkg::word_t OP_JIRL    = 32'h4c000000;
    localparam la32_pkg::word_t OP_B       = 32'h50000000;
    localparam la32_pkg::word_t OP_BL      = 32'h54000000;
    localparam la32_pkg::word_t OP_BEQ     = 32'h58000000;
    localparam la32_pkg::word_t OP_BNE     = 32'h5c000000;
    localparam la32_pkg::word_t PRELOAD    = 32'h3c5a96e1;

    logic               clk;
    logic               reset;
    la32_pkg::word_t    inst_sram_addr;
    la32_pkg::word_t    inst_sram_rdata;
    logic               data_sram_we;
    la32_pkg::word_t    data_sram_addr;
    la32_pkg::word_t    data_sram_wdata;
    la32_pkg::word_t    data_sram_rdata;
    logic               debug_wb_valid;
    la32_pkg::word_t    debug_wb_pc;
    logic               debug_wb_rf_we;
    la32_pkg::reg_idx_t debug_wb_rf_wnum;
    la32_pkg::word_t    debug_wb_rf_wdata;

    la32_pkg::word_t imem [256];
    la32_pkg::word_t dmem [256];
    la32_pkg::word_t rf_m [32];  // expected register contents while the program is built.
    row_t            rows [$];
    la32_pkg::word_t cur_pc;
    la32_pkg::word_t poison;
    la32_pkg::word_t stored_word;
    integer          seed;
    int              cycles = 0;
    int              limit = 0;
    int              errors = 0;
    int              checks = 0;
    int              last_strobe;

    tb_clock clock_i (
        .clk   (clk),
        .reset (reset)
    );

    la32_core dut_i (
        .clk               (clk),
        .reset             (reset),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_we      (data_sram_we),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_valid    (debug_wb_valid),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    // both SRAMs answer one cycle after the address.
    always @(posedge clk) begin
        inst_sram_rdata <= imem[inst_sram_addr[9:2]];
        data_sram_rdata <= dmem[data_sram_addr[9:2]];
        if (data_sram_we) begin
            dmem[data_sram_addr[9:2]] <= data_sram_wdata;
        end
    end

    function automatic la32_pkg::word_t rm(la32_pkg::reg_idx_t i);
        return (i == 5'd0) ? 32'd0 : rf_m[i];
    endfunction

    function automatic la32_pkg::word_t sext12(logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic la32_pkg::word_t enc_3r(la32_pkg::word_t base, la32_pkg::reg_idx_t rd,
                                               la32_pkg::reg_idx_t rj, la32_pkg::reg_idx_t rk);
        return base | {17'b0, rk, rj, rd};
    endfunction

    function automatic la32_pkg::word_t enc_ri12(la32_pkg::word_t base, la32_pkg::reg_idx_t rd,
                                                 la32_pkg::reg_idx_t rj, logic [11:0] si12);
        return base | {10'b0, si12, rj, rd};
    endfunction

    function automatic la32_pkg::word_t enc_ri16(la32_pkg::word_t base, la32_pkg::reg_idx_t rd,
                                                 la32_pkg::reg_idx_t rj, logic [15:0] offs);
        return base | {6'b0, offs, rj, rd};  // offs counts words, not bytes.
    endfunction

    function automatic la32_pkg::word_t enc_i26(la32_pkg::word_t base, logic [25:0] offs);
        return base | {6'b0, offs[15:0], offs[25:16]};
    endfunction

    function automatic la32_pkg::word_t enc_ri20(la32_pkg::word_t base, la32_pkg::reg_idx_t rd,
                                                 logic [19:0] si20);
        return base | {7'b0, si20, rd};
    endfunction

    task automatic place(la32_pkg::word_t addr, la32_pkg::word_t word);
        imem[addr[9:2]] = word;
    endtask

    task automatic emit(la32_pkg::word_t word, la32_pkg::inst_e op, logic we,
                        la32_pkg::reg_idx_t wnum, la32_pkg::word_t wdata,
                        la32_pkg::word_t next_pc);
        row_t r;
        r.pc    = cur_pc;
        r.inst  = word;
        r.op    = op;
        r.we    = we;
        r.wnum  = wnum;
        r.wdata = wdata;
        rows.push_back(r);
        if (we && wnum != 5'd0) rf_m[wnum] = wdata;
        cur_pc = next_pc;
    endtask

    task automatic rrr(la32_pkg::word_t base, la32_pkg::inst_e op, la32_pkg::reg_idx_t rd,
                       la32_pkg::reg_idx_t rj, la32_pkg::reg_idx_t rk, la32_pkg::word_t value);
        emit(enc_3r(base, rd, rj, rk), op, 1'b1, rd, value, cur_pc + 4);
    endtask

    // a taken forward branch; the words it jumps over must never retire.
    task automatic branch(la32_pkg::word_t word, la32_pkg::inst_e op, la32_pkg::word_t offset);
        la32_pkg::word_t pc0;
        la32_pkg::word_t p;
        pc0 = cur_pc;
        emit(word, op, 1'b0, 5'd0, 32'd0, pc0 + offset);
        for (p = pc0 + 4; p < pc0 + offset; p = p + 4) place(p, poison);
    endtask

    task automatic load_const(la32_pkg::reg_idx_t rd, la32_pkg::word_t v);
        emit(enc_ri20(OP_LU12I_W, rd, v[31:12]), la32_pkg::INST_LU12I_W, 1'b1, rd,
             {v[31:12], 12'b0}, cur_pc + 4);
        emit(enc_ri12(OP_ADDI_W, rd, rd, v[11:0]), la32_pkg::INST_ADDI_W, 1'b1, rd,
             rm(rd) + sext12(v[11:0]), cur_pc + 4);
    endtask

    task automatic build_program();
        la32_pkg::word_t a;
        la32_pkg::word_t b;
        la32_pkg::word_t sh;
        la32_pkg::word_t va;
        la32_pkg::word_t vb;
        la32_pkg::word_t p;
        logic [7:0]      k;
        for (int i = 0; i < 256; i++) begin
            k = i[7:0];
            imem[i] = {24'hffffff, k};  // opcode 111111 decodes as invalid.
            dmem[i] = {k, ~k, k ^ 8'h5a, k + 8'h33};
        end
        dmem[8] = PRELOAD;
        for (int i = 0; i < 32; i++) rf_m[i] = 32'd0;
        cur_pc = la32_pkg::RESET_PC;
        poison = enc_ri12(OP_ADDI_W, 5'd25, 5'd0, 12'h7ff);
        seed = 32'h44a8;
        a  = $random(seed);
        b  = $random(seed);
        sh = $random(seed);
        load_const(5'd4, a);
        load_const(5'd5, b);
        va = rm(5'd4);
        vb = rm(5'd5);
        rrr(OP_ADD_W, la32_pkg::INST_ADD_W, 5'd6, 5'd4, 5'd5, va + vb);
        rrr(OP_SUB_W, la32_pkg::INST_SUB_W, 5'd7, 5'd4, 5'd5, va - vb);
        rrr(OP_SLT, la32_pkg::INST_SLT, 5'd8, 5'd4, 5'd5, {31'b0, $signed(va) < $signed(vb)});
        rrr(OP_SLTU, la32_pkg::INST_SLTU, 5'd9, 5'd4, 5'd5, {31'b0, va < vb});
        rrr(OP_NOR, la32_pkg::INST_NOR, 5'd10, 5'd4, 5'd5, ~(va | vb));
        rrr(OP_AND, la32_pkg::INST_AND, 5'd11, 5'd4, 5'd5, va & vb);
        rrr(OP_OR, la32_pkg::INST_OR, 5'd12, 5'd4, 5'd5, va | vb);
        rrr(OP_XOR, la32_pkg::INST_XOR, 5'd13, 5'd4, 5'd5, va ^ vb);
        rrr(OP_SLLI_W, la32_pkg::INST_SLLI_W, 5'd14, 5'd4, sh[4:0], va << sh[4:0]);
        rrr(OP_SRLI_W, la32_pkg::INST_SRLI_W, 5'd15, 5'd4, sh[9:5], va >> sh[9:5]);
        rrr(OP_SRAI_W, la32_pkg::INST_SRAI_W, 5'd16, 5'd4, sh[14:10],
            la32_pkg::word_t'($signed(va) >>> sh[14:10]));
        emit(enc_ri12(OP_ADDI_W, 5'd17, 5'd0, 12'hffd), la32_pkg::INST_ADDI_W, 1'b1, 5'd17,
             32'hfffffffd, cur_pc + 4);
        rrr(OP_SRAI_W, la32_pkg::INST_SRAI_W, 5'd18, 5'd17, 5'd1, 32'hfffffffe);
        rrr(OP_SRLI_W, la32_pkg::INST_SRLI_W, 5'd19, 5'd17, 5'd1, 32'h7ffffffe);
        emit(enc_ri12(OP_ADDI_W, 5'd0, 5'd4, 12'd5), la32_pkg::INST_ADDI_W, 1'b1, 5'd0,
             va + 32'd5, cur_pc + 4);  // traced, but r0 keeps reading zero.
        rrr(OP_ADD_W, la32_pkg::INST_ADD_W, 5'd20, 5'd0, 5'd5, vb);
        stored_word = rm(5'd6);
        emit(enc_ri12(OP_ST_W, 5'd6, 5'd0, 12'h010), la32_pkg::INST_ST_W, 1'b0, 5'd0, 32'd0,
             cur_pc + 4);
        emit(enc_ri12(OP_LD_W, 5'd21, 5'd0, 12'h010), la32_pkg::INST_LD_W, 1'b1, 5'd21,
             stored_word, cur_pc + 4);
        emit(enc_ri12(OP_LD_W, 5'd22, 5'd0, 12'h020), la32_pkg::INST_LD_W, 1'b1, 5'd22,
             PRELOAD, cur_pc + 4);
        branch(enc_ri16(OP_BEQ, 5'd6, 5'd21, 16'd2), la32_pkg::INST_BEQ, 32'd8);
        emit(enc_ri16(OP_BNE, 5'd6, 5'd21, 16'd2), la32_pkg::INST_BNE, 1'b0, 5'd0, 32'd0,
             cur_pc + 4);
        emit(enc_ri16(OP_BEQ, 5'd17, 5'd0, 16'd2), la32_pkg::INST_BEQ, 1'b0, 5'd0, 32'd0,
             cur_pc + 4);
        branch(enc_ri16(OP_BNE, 5'd17, 5'd0, 16'd2), la32_pkg::INST_BNE, 32'd8);
        branch(enc_i26(OP_B, 26'd3), la32_pkg::INST_B, 32'd12);
        emit(32'hfc000000, la32_pkg::INST_INVALID, 1'b0, 5'd0, 32'd0, cur_pc + 4);
        // bl jumps over a call site, jirl returns into it, and b leaves the block.
        p = cur_pc;
        emit(enc_i26(OP_BL, 26'd3), la32_pkg::INST_BL, 1'b1, la32_pkg::LINK_REG, p + 4, p + 12);
        emit(enc_ri16(OP_JIRL, 5'd0, 5'd1, 16'd0), la32_pkg::INST_JIRL, 1'b1, 5'd0, p + 16,
             rm(5'd1));
        emit(enc_ri12(OP_ADDI_W, 5'd23, 5'd0, 12'h123), la32_pkg::INST_ADDI_W, 1'b1, 5'd23,
             32'h123, cur_pc + 4);
        emit(enc_i26(OP_B, 26'd3), la32_pkg::INST_B, 1'b0, 5'd0, 32'd0, p + 20);
        place(p + 16, poison);
        rrr(OP_ADD_W, la32_pkg::INST_ADD_W, 5'd24, 5'd23, 5'd1, 32'h123 + p + 4);
    endtask

    task automatic check_word(input string name, input la32_pkg::word_t exp,
                              input la32_pkg::word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_reg(input string name, input la32_pkg::reg_idx_t exp,
                             input la32_pkg::reg_idx_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_op(input string name, input la32_pkg::inst_e exp,
                            input la32_pkg::inst_e act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s expected %s, got %s", $time, name, exp.name(),
                     act.name());
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            errors++;
            $display("** Error at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic finish_run();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles > limit) begin
            errors = errors + 1;
            $display("timeout: the core stopped retiring instructions after %0d cycles", cycles);
            finish_run();
        end
    end

    // outputs are sampled on the falling edge, half a cycle after they settle.
    initial begin
        inst_sram_rdata = 32'd0;
        data_sram_rdata = 32'd0;
        build_program();
        foreach (rows[i]) place(rows[i].pc, rows[i].inst);
        limit = 5 * rows.size() + 16 + 50;
        @(negedge clk);
        while (reset) @(negedge clk);
        check_word("inst_sram_addr", la32_pkg::RESET_PC, inst_sram_addr);
        check_bit("debug_wb_valid", 1'b0, debug_wb_valid);
        check_bit("debug_wb_rf_we", 1'b0, debug_wb_rf_we);
        check_bit("data_sram_we", 1'b0, data_sram_we);
        last_strobe = cycles;
        for (int i = 0; i < rows.size(); i++) begin
            do @(negedge clk); while (!debug_wb_valid);
            check_count($sformatf("strobe spacing[%0d]", i), (i == 0) ? 4 : 5,
                        cycles - last_strobe);
            last_strobe = cycles;
            check_word($sformatf("debug_wb_pc[%0d]", i), rows[i].pc, debug_wb_pc);
            check_op($sformatf("decoded op[%0d]", i), rows[i].op, dut_i.dec_bus.op);
            check_bit($sformatf("debug_wb_rf_we[%0d]", i), rows[i].we, debug_wb_rf_we);
            if (rows[i].we) begin
                check_reg($sformatf("debug_wb_rf_wnum[%0d]", i), rows[i].wnum, debug_wb_rf_wnum);
                check_word($sformatf("debug_wb_rf_wdata[%0d]", i), rows[i].wdata,
                           debug_wb_rf_wdata);
            end
        end
        check_word("dmem[0x10]", stored_word, dmem[4]);
        finish_run();
    end

endmodule

/* verif/la32_core_props.sv */
module la32_core_props (
    input logic clk,
    input logic reset,
    input logic debug_wb_valid,
    input logic data_sram_we
);

    timeunit 1ns;
    timeprecision 100ps;

    // each instruction takes five states, so strobes are at least five cycles apart.
    a_strobe_gap: assert property (@(posedge clk) disable iff (reset)
        !(debug_wb_valid && ($past(debug_wb_valid, 1) || $past(debug_wb_valid, 2) ||
                             $past(debug_wb_valid, 3) || $past(debug_wb_valid, 4))))
        else $error("debug_wb_valid strobed again within four cycles");

    // a store owns the data SRAM for the single MEM cycle.
    a_single_write: assert property (@(posedge clk) disable iff (reset)
        !(data_sram_we && $past(data_sram_we)))
        else $error("data_sram_we stayed high for two cycles");

    a_quiet_in_reset: assert property (@(posedge clk)
        (reset && $past(reset)) |-> !debug_wb_valid)
        else $error("an instruction retired while reset was high");

endmodule

bind la32_core la32_core_props props_i (
    .clk            (clk),
    .reset          (reset),
    .debug_wb_valid (debug_wb_valid),
    .data_sram_we   (data_sram_we)
);

/* verif/tb_clock.sv */
module tb_clock (
    output logic clk,
    output logic reset
);

    timeunit 1ns;
    timeprecision 100ps;

    initial clk = 1'b0;

    always #2 clk = ~clk;  // 4 ns period.

    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

/* verilog/la32_core.sv */
module la32_core (
    input  logic               clk,
    input  logic               reset,
    // instruction SRAM, read only.
    output la32_pkg::word_t    inst_sram_addr,
    input  la32_pkg::word_t    inst_sram_rdata,
    // data SRAM, word access.
    output logic               data_sram_we,
    output la32_pkg::word_t    data_sram_addr,
    output la32_pkg::word_t    data_sram_wdata,
    input  la32_pkg::word_t    data_sram_rdata,
    // retirement trace.
    output logic               debug_wb_valid,
    output la32_pkg::word_t    debug_wb_pc,
    output logic               debug_wb_rf_we,
    output la32_pkg::reg_idx_t debug_wb_rf_wnum,
    output la32_pkg::word_t    debug_wb_rf_wdata
);

    la32_pkg::state_e state;
    la32_pkg::state_e state_nxt;
    la32_pkg::word_t  pc;
    la32_pkg::word_t  inst_q;
    la32_pkg::word_t  result_q;
    la32_pkg::word_t  next_pc_q;
    la32_pkg::word_t  rj_value;
    la32_pkg::word_t  rkd_value;
    la32_pkg::word_t  alu_src1;
    la32_pkg::word_t  alu_src2;
    la32_pkg::word_t  alu_result;
    la32_pkg::word_t  br_target;
    la32_pkg::word_t  final_result;
    logic             rj_eq_rkd;
    logic             br_taken;
    logic             rf_we;

    dec_if dec_bus ();

    la32_decoder decoder_i (
        .inst (inst_q),
        .ctrl (dec_bus.dec)
    );

    la32_regfile regfile_i (
        .clk    (clk),
        .raddr1 (dec_bus.rj),
        .rdata1 (rj_value),
        .raddr2 (dec_bus.rkd),
        .rdata2 (rkd_value),
        .we     (rf_we),
        .waddr  (dec_bus.dest),
        .wdata  (final_result)
    );

    assign alu_src1 = dec_bus.src1_is_pc  ? pc          : rj_value;
    assign alu_src2 = dec_bus.src2_is_imm ? dec_bus.imm : rkd_value;

    la32_alu alu_i (
        .alu_op (dec_bus.alu_op),
        .src1   (alu_src1),
        .src2   (alu_src2),
        .result (alu_result)
    );

    always_comb begin
        case (state)
            la32_pkg::IF:  state_nxt = la32_pkg::ID;
            la32_pkg::ID:  state_nxt = la32_pkg::EXE;
            la32_pkg::EXE: state_nxt = la32_pkg::MEM;
            la32_pkg::MEM: state_nxt = la32_pkg::WB;
            default:       state_nxt = la32_pkg::IF;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= la32_pkg::IF;
            pc    <= la32_pkg::RESET_PC;
        end else begin
            state <= state_nxt;
            if (state == la32_pkg::WB) begin
                pc <= next_pc_q;  // the retiring instruction hands over its successor.
            end
        end
    end

    assign rj_eq_rkd = (rj_value == rkd_value);

    always_comb begin
        case (dec_bus.op)
            la32_pkg::INST_BEQ:  br_taken = rj_eq_rkd;
            la32_pkg::INST_BNE:  br_taken = !rj_eq_rkd;
            la32_pkg::INST_B,
            la32_pkg::INST_BL,
            la32_pkg::INST_JIRL: br_taken = 1'b1;
            default:             br_taken = 1'b0;
        endcase
    end

    // jirl jumps relative to rj, every other branch relative to its own pc.
    assign br_target = ((dec_bus.op == la32_pkg::INST_JIRL) ? rj_value : pc) + dec_bus.br_offs;

    always_ff @(posedge clk) begin
        if (state == la32_pkg::ID) begin
            inst_q <= inst_sram_rdata;
        end
        if (state == la32_pkg::EXE) begin
            result_q  <= alu_result;
            next_pc_q <= br_taken ? br_target : pc + 32'd4;
        end
    end

    assign inst_sram_addr = pc;

    assign data_sram_we    = (state == la32_pkg::MEM) && dec_bus.mem_we;
    assign data_sram_addr  = result_q;
    assign data_sram_wdata = rkd_value;  // rd of a store, read through the second port.

    // load data arrives in WB, one cycle after the address went out in MEM.
    assign final_result = dec_bus.res_from_mem ? data_sram_rdata : result_q;
    assign rf_we        = (state == la32_pkg::WB) && dec_bus.gr_we;

    assign debug_wb_valid    = (state == la32_pkg::WB);
    assign debug_wb_pc       = pc;
    assign debug_wb_rf_we    = rf_we;
    assign debug_wb_rf_wnum  = dec_bus.dest;
    assign debug_wb_rf_wdata = final_result;

endmodule

/* verilog/la32_alu.sv */
module la32_alu (
    input  la32_pkg::alu_op_e alu_op,
    input  la32_pkg::word_t   src1,
    input  la32_pkg::word_t   src2,
    output la32_pkg::word_t   result
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = src2[4:0];  // shifts use only the low five bits.
    assign lt_signed   = $signed(src1) < $signed(src2);
    assign lt_unsigned = src1 < src2;

    always_comb begin
        case (alu_op)
            la32_pkg::ALU_ADD:  result = src1 + src2;
            la32_pkg::ALU_SUB:  result = src1 - src2;
            la32_pkg::ALU_SLT:  result = {31'b0, lt_signed};
            la32_pkg::ALU_SLTU: result = {31'b0, lt_unsigned};
            la32_pkg::ALU_AND:  result = src1 & src2;
            la32_pkg::ALU_NOR:  result = ~(src1 | src2);
            la32_pkg::ALU_OR:   result = src1 | src2;
            la32_pkg::ALU_XOR:  result = src1 ^ src2;
            la32_pkg::ALU_SLL:  result = src1 << shamt;
            la32_pkg::ALU_SRL:  result = src1 >> shamt;
            la32_pkg::ALU_SRA:  result = $unsigned($signed(src1) >>> shamt);
            la32_pkg::ALU_LUI:  result = src2;  // the decoder already shifted the immediate.
            default:            result = 32'd0;
        endcase
    end

endmodule

/* verilog/la32_regfile.sv */
module la32_regfile (
    input  logic               clk,
    input  la32_pkg::reg_idx_t raddr1,
    output la32_pkg::word_t    rdata1,
    input  la32_pkg::reg_idx_t raddr2,
    output la32_pkg::word_t    rdata2,
    input  logic               we,
    input  la32_pkg::reg_idx_t waddr,
    input  la32_pkg::word_t    wdata
);

    la32_pkg::word_t rf [32];

    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin
            rf[waddr] <= wdata;
        end
    end

    // r0 is hardwired to zero, whatever was written to it.
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : rf[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : rf[raddr2];

endmodule

/* verilog/la32_decoder.sv */
module la32_decoder (
    input la32_pkg::word_t inst,
    dec_if.dec             ctrl
);

    la32_pkg::inst_e    op;
    la32_pkg::reg_idx_t rd;
    logic               src2_is_4;
    logic               need_ui5;
    logic               src_reg_is_rd;
    logic [11:0]        si12;
    logic [19:0]        si20;
    logic [15:0]        si16;
    logic [25:0]        si26;

    assign rd   = inst[4:0];
    assign si12 = inst[21:10];
    assign si20 = inst[24:5];
    assign si16 = inst[25:10];
    assign si26 = {inst[9:0], inst[25:10]};  // the high offset bits sit in the low field.

    // the pattern is op[31:26], op[25:22], op[21:20], op[19:15].
    always_comb begin
        casez (inst[31:15])
            17'b000000_0000_01_00000: op = la32_pkg::INST_ADD_W;
            17'b000000_0000_01_00010: op = la32_pkg::INST_SUB_W;
            17'b000000_0000_01_00100: op = la32_pkg::INST_SLT;
            17'b000000_0000_01_00101: op = la32_pkg::INST_SLTU;
            17'b000000_0000_01_01000: op = la32_pkg::INST_NOR;
            17'b000000_0000_01_01001: op = la32_pkg::INST_AND;
            17'b000000_0000_01_01010: op = la32_pkg::INST_OR;
            17'b000000_0000_01_01011: op = la32_pkg::INST_XOR;
            17'b000000_0001_00_00001: op = la32_pkg::INST_SLLI_W;
            17'b000000_0001_00_01001: op = la32_pkg::INST_SRLI_W;
            17'b000000_0001_00_10001: op = la32_pkg::INST_SRAI_W;
            17'b000000_1010_??_?????: op = la32_pkg::INST_ADDI_W;
            17'b000101_0???_??_?????: op = la32_pkg::INST_LU12I_W;
            17'b001010_0010_??_?????: op = la32_pkg::INST_LD_W;
            17'b001010_0110_??_?????: op = la32_pkg::INST_ST_W;
            17'b010011_????_??_?????: op = la32_pkg::INST_JIRL;
            17'b010100_????_??_?????: op = la32_pkg::INST_B;
            17'b010101_????_??_?????: op = la32_pkg::INST_BL;
            17'b010110_????_??_?????: op = la32_pkg::INST_BEQ;
            17'b010111_????_??_?????: op = la32_pkg::INST_BNE;
            default:                  op = la32_pkg::INST_INVALID;
        endcase
    end

    always_comb begin
        case (op)
            la32_pkg::INST_SUB_W:   ctrl.alu_op = la32_pkg::ALU_SUB;
            la32_pkg::INST_SLT:     ctrl.alu_op = la32_pkg::ALU_SLT;
            la32_pkg::INST_SLTU:    ctrl.alu_op = la32_pkg::ALU_SLTU;
            la32_pkg::INST_AND:     ctrl.alu_op = la32_pkg::ALU_AND;
            la32_pkg::INST_NOR:     ctrl.alu_op = la32_pkg::ALU_NOR;
            la32_pkg::INST_OR:      ctrl.alu_op = la32_pkg::ALU_OR;
            la32_pkg::INST_XOR:     ctrl.alu_op = la32_pkg::ALU_XOR;
            la32_pkg::INST_SLLI_W:  ctrl.alu_op = la32_pkg::ALU_SLL;
            la32_pkg::INST_SRLI_W:  ctrl.alu_op = la32_pkg::ALU_SRL;
            la32_pkg::INST_SRAI_W:  ctrl.alu_op = la32_pkg::ALU_SRA;
            la32_pkg::INST_LU12I_W: ctrl.alu_op = la32_pkg::ALU_LUI;
            default:                ctrl.alu_op = la32_pkg::ALU_ADD;  // also forms addresses and links.
        endcase
    end

    assign need_ui5      = op inside {la32_pkg::INST_SLLI_W, la32_pkg::INST_SRLI_W,
                                      la32_pkg::INST_SRAI_W};
    assign src2_is_4     = op inside {la32_pkg::INST_JIRL, la32_pkg::INST_BL};
    assign src_reg_is_rd = op inside {la32_pkg::INST_ST_W, la32_pkg::INST_BEQ,
                                      la32_pkg::INST_BNE};

    assign ctrl.op           = op;
    assign ctrl.src1_is_pc   = src2_is_4;  // links compute pc + 4.
    assign ctrl.src2_is_imm  = need_ui5 || src2_is_4 ||
                               op inside {la32_pkg::INST_ADDI_W, la32_pkg::INST_LU12I_W,
                                          la32_pkg::INST_LD_W, la32_pkg::INST_ST_W};
    assign ctrl.res_from_mem = (op == la32_pkg::INST_LD_W);
    assign ctrl.mem_we       = (op == la32_pkg::INST_ST_W);
    assign ctrl.gr_we        = !(op inside {la32_pkg::INST_ST_W, la32_pkg::INST_BEQ,
                                            la32_pkg::INST_BNE, la32_pkg::INST_B,
                                            la32_pkg::INST_INVALID});

    assign ctrl.rj   = inst[9:5];
    assign ctrl.rkd  = src_reg_is_rd ? rd : inst[14:10];
    assign ctrl.dest = (op == la32_pkg::INST_BL) ? la32_pkg::LINK_REG : rd;

    always_comb begin
        if (src2_is_4)
            ctrl.imm = 32'd4;
        else if (op == la32_pkg::INST_LU12I_W)
            ctrl.imm = {si20, 12'b0};
        else if (need_ui5)
            ctrl.imm = {27'b0, inst[14:10]};
        else
            ctrl.imm = {{20{si12[11]}}, si12};
    end

    assign ctrl.br_offs = (op inside {la32_pkg::INST_B, la32_pkg::INST_BL}) ?
                          {{4{si26[25]}}, si26, 2'b0} : {{14{si16[15]}}, si16, 2'b0};

endmodule

/* verilog/dec_if.sv */
interface dec_if;

    la32_pkg::inst_e    op;
    la32_pkg::alu_op_e  alu_op;
    logic               src1_is_pc;
    logic               src2_is_imm;
    logic               res_from_mem;
    logic               gr_we;
    logic               mem_we;
    la32_pkg::reg_idx_t rj;
    la32_pkg::reg_idx_t rkd;   // rk, or rd for stores and branches.
    la32_pkg::reg_idx_t dest;
    la32_pkg::word_t    imm;
    la32_pkg::word_t    br_offs;

    modport dec (
        output op, alu_op, src1_is_pc, src2_is_imm, res_from_mem, gr_we, mem_we,
        output rj, rkd, dest, imm, br_offs
    );

    modport core (
        input op, alu_op, src1_is_pc, src2_is_imm, res_from_mem, gr_we, mem_we,
        input rj, rkd, dest, imm, br_offs
    );

endinterface

/* verilog/la32_pkg.sv */
package la32_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // every instruction walks through all five states in order.
    typedef enum logic [2:0] {
        IF,
        ID,
        EXE,
        MEM,
        WB
    } state_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_NOR,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI     // passes the second operand through.
    } alu_op_e;

    typedef enum logic [4:0] {
        INST_ADD_W,
        INST_SUB_W,
        INST_SLT,
        INST_SLTU,
        INST_NOR,
        INST_AND,
        INST_OR,
        INST_XOR,
        INST_SLLI_W,
        INST_SRLI_W,
        INST_SRAI_W,
        INST_ADDI_W,
        INST_LU12I_W,
        INST_LD_W,
        INST_ST_W,
        INST_JIRL,
        INST_B,
        INST_BL,
        INST_BEQ,
        INST_BNE,
        INST_INVALID  // anything outside the supported subset.
    } inst_e;

    localparam word_t    RESET_PC = 32'h1c000000;
    localparam reg_idx_t LINK_REG = 5'd1;  // bl writes its return address here.

endpackage
